// File: files.f
conv_pkg.sv
conv_weight_regs.sv
conv_window_gen.sv
conv_mac_lane.sv
conv_result_serializer.sv
conv_engine_top.sv
tb_conv_engine.sv

// File: Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP := tb_conv_engine
FILELIST := files.f
OBJ_DIR := obj_dir

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_conv_engine.sv
module tb_conv_engine;
	import conv_pkg::*;

	localparam int N_LANES = 4;
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int PERIOD = 8;
	localparam int BEATS = N_LANES * (IMG_W - 2) * (IMG_H - 2);
	// three frames of beats at full stall, eight periods each, plus margin
	localparam int WATCHDOG = (3 * BEATS * 8 + 2000) * PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic [AXIL_ADDR_W-1:0] s_axil_awaddr;
	logic s_axil_awvalid;
	logic s_axil_awready;
	logic [AXIL_DATA_W-1:0] s_axil_wdata;
	logic [AXIL_DATA_W/8-1:0] s_axil_wstrb;
	logic s_axil_wvalid;
	logic s_axil_wready;
	logic s_axil_bvalid;
	axil_resp_t s_axil_bresp;
	logic s_axil_bready;
	logic [AXIL_ADDR_W-1:0] s_axil_araddr;
	logic s_axil_arvalid;
	logic s_axil_arready;
	logic [AXIL_DATA_W-1:0] s_axil_rdata;
	axil_resp_t s_axil_rresp;
	logic s_axil_rvalid;
	logic s_axil_rready;
	logic pxl_valid;
	pixel_t pxl_data;
	logic pxl_ready;
	logic out_valid;
	result_t out_data;
	logic out_ready;

	logic [31:0] lfsr_state = 32'hde34_429b;
	string test_name = "reset";
	weight_t wts [N_LANES][9];
	pixel_t pix_q [$];
	result_t exp_q [$];
	result_t exp_beat;
	logic exp_ok = 1'b0;
	axil_resp_t exp_bresp = OKAY;
	axil_resp_t exp_rresp = OKAY;
	logic [31:0] exp_rdata = '0;
	logic random_flow = 1'b0;
	logic pxl_take = 1'b0;
	logic beat_take = 1'b0;
	int cycle = 0;
	int pxl_count = 0;
	int probe_at = -1;
	int lat_due = -1;

	conv_engine_top #(
		.N_LANES     (N_LANES),
		.IMAGE_WIDTH (IMG_W),
		.IMAGE_HEIGHT(IMG_H)
	) uut (
		.clk           (clk),
		.reset         (reset),
		.s_axil_awaddr (s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata  (s_axil_wdata),
		.s_axil_wstrb  (s_axil_wstrb),
		.s_axil_wvalid (s_axil_wvalid),
		.s_axil_wready (s_axil_wready),
		.s_axil_bvalid (s_axil_bvalid),
		.s_axil_bresp  (s_axil_bresp),
		.s_axil_bready (s_axil_bready),
		.s_axil_araddr (s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata  (s_axil_rdata),
		.s_axil_rresp  (s_axil_rresp),
		.s_axil_rvalid (s_axil_rvalid),
		.s_axil_rready (s_axil_rready),
		.pxl_valid     (pxl_valid),
		.pxl_data      (pxl_data),
		.pxl_ready     (pxl_ready),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_ready     (out_ready)
	);

	always #(PERIOD / 2) clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], rand_bit()};
		end
		return v;
	endfunction

	function automatic void value_error(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		$display("TEST FAIL");
		$fatal(1);
	endfunction

	function automatic void flow_error(input string msg);
		$display("error in %s: %s", test_name, msg);
		$display("TEST FAIL");
		$fatal(1);
	endfunction

	////////////////////
	// axi4-lite

	task automatic axil_write(input int lane, input int tap, input logic [31:0] data,
		input axil_resp_t resp);
		logic aw_done;
		logic w_done;
		@(negedge clk);
		exp_bresp = resp;
		s_axil_awaddr = AXIL_ADDR_W'(lane * 64 + tap * 4);
		s_axil_wdata = data;
		s_axil_wstrb = 4'hf;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid = 1'b1;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done)) begin
			#1;
			if (s_axil_awvalid && s_axil_awready) begin
				aw_done = 1'b1;
			end
			if (s_axil_wvalid && s_axil_wready) begin
				w_done = 1'b1;
			end
			@(negedge clk);
			if (aw_done) begin
				s_axil_awvalid = 1'b0;
			end
			if (w_done) begin
				s_axil_wvalid = 1'b0;
			end
		end
		while (!s_axil_bvalid) begin
			@(negedge clk);
		end
	endtask

	task automatic axil_read(input int lane, input int tap, input logic [31:0] data,
		input axil_resp_t resp);
		@(negedge clk);
		exp_rdata = data;
		exp_rresp = resp;
		s_axil_araddr = AXIL_ADDR_W'(lane * 64 + tap * 4);
		s_axil_arvalid = 1'b1;
		#1;
		while (!s_axil_arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		s_axil_arvalid = 1'b0;
		while (!s_axil_rvalid) begin
			@(negedge clk);
		end
	endtask

	////////////////////
	// frame model

	// random frame into the pixel queue, expected sums into the result queue
	task automatic load_frame();
		int pix [IMG_H][IMG_W];
		int sum;
		result_t res;
		for (int row = 0; row < IMG_H; row++) begin
			for (int col = 0; col < IMG_W; col++) begin
				pix[row][col] = int'(rand_bits(8));
				pix_q.push_back(pixel_t'(pix[row][col]));
			end
		end
		// windows in raster order of their top left corner
		for (int row = 0; row < IMG_H - 2; row++) begin
			for (int col = 0; col < IMG_W - 2; col++) begin
				for (int lane = 0; lane < N_LANES; lane++) begin
					sum = 0;
					for (int t = 0; t < 9; t++) begin
						sum += pix[row + t / 3][col + t % 3] * int'(wts[lane][t]);
					end
					res.sum = acc_t'(sum);
					res.chan = 8'(lane);
					res.last = (row == IMG_H - 3) && (col == IMG_W - 3) && (lane == N_LANES - 1);
					exp_q.push_back(res);
				end
			end
		end
	endtask

	task automatic drain();
		while (pix_q.size() > 0 || exp_q.size() > 0 || pxl_valid) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);
	endtask

	// pixels in, out_ready, and the beat due at the next edge
	always begin
		@(negedge clk);
		cycle++;
		if (pxl_take) begin
			void'(pix_q.pop_front());
			pxl_valid = 1'b0;
		end
		if (!pxl_valid && pix_q.size() > 0 && (!random_flow || rand_bit())) begin
			pxl_valid = 1'b1;
			pxl_data = pix_q[0];
		end
		out_ready = random_flow ? rand_bit() : 1'b1;
		#1;
		pxl_take = pxl_valid && pxl_ready;
		if (pxl_take) begin
			if (pxl_count == probe_at) begin
				lat_due = cycle + 4;
			end
			pxl_count++;
		end
		beat_take = out_valid && out_ready;
		if (beat_take) begin
			exp_ok = (exp_q.size() > 0);
			if (exp_ok) begin
				exp_beat = exp_q.pop_front();
			end
		end
	end

	////////////////////
	// checks

	assert property (@(posedge clk) $fell(reset) |->
		!out_valid && !s_axil_bvalid && !s_axil_rvalid && pxl_ready)
		else flow_error("outputs not at their idle values after reset");

	assert property (@(posedge clk) disable iff (reset)
		s_axil_bvalid && s_axil_bready |-> s_axil_bresp == exp_bresp)
		else value_error("bresp", 64'(exp_bresp), 64'(s_axil_bresp));

	assert property (@(posedge clk) disable iff (reset)
		s_axil_rvalid && s_axil_rready |-> {s_axil_rresp, s_axil_rdata} == {exp_rresp, exp_rdata})
		else value_error("read", 64'({exp_rresp, exp_rdata}), 64'({s_axil_rresp, s_axil_rdata}));

	assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> exp_ok)
		else flow_error("an output beat arrived with no result left to expect");

	assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready && exp_ok |-> out_data == exp_beat)
		else value_error("result", 64'(exp_beat), 64'(out_data));

	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else flow_error("a stalled output beat changed or vanished");

	// first window of an idle pipeline
	assert property (@(posedge clk) disable iff (reset)
		cycle == lat_due |-> out_valid && out_data.chan == 8'd0 && !$past(out_valid))
		else flow_error("first chan 0 beat did not appear 4 cycles after its pixel");

	initial begin
		#(WATCHDOG);
		$display("timeout after %0d time units, the run did not finish", WATCHDOG);
		$display("TEST FAIL");
		$fatal(1);
	end

	initial begin
		logic [31:0] word;
		reset = 1'b1;
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b1;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b1;
		pxl_valid = 1'b0;
		pxl_data = '0;
		out_ready = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "readback";
		for (int lane = 0; lane < N_LANES; lane++) begin
			for (int tap = 0; tap < 9; tap++) begin
				word = rand_bits(32);
				wts[lane][tap] = weight_t'(word[7:0]);
				axil_write(lane, tap, word, OKAY);
			end
		end
		for (int lane = 0; lane < N_LANES; lane++) begin
			for (int tap = 0; tap < 9; tap++) begin
				axil_read(lane, tap, int'(wts[lane][tap]), OKAY);
			end
		end
		axil_write(0, 9, 32'h0000_0055, SLVERR);
		axil_write(N_LANES, 0, 32'h0000_007f, SLVERR);
		axil_read(0, 9, '0, SLVERR);
		axil_read(N_LANES, 0, '0, SLVERR);

		test_name = "latency";
		@(posedge clk);
		// row 2, column 2 completes the frame's first window
		probe_at = pxl_count + 2 * IMG_W + 2;
		load_frame();
		drain();

		test_name = "backpressure";
		@(posedge clk);
		load_frame();
		load_frame();
		random_flow = 1'b1;
		drain();
		random_flow = 1'b0;

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: conv_engine_top.sv
module conv_engine_top #(
	parameter int N_LANES = 4,
	parameter int IMAGE_WIDTH = 8,
	parameter int IMAGE_HEIGHT = 8
) (
	input logic clk,
	input logic reset,
	input logic [conv_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input logic [conv_pkg::AXIL_DATA_W-1:0] s_axil_wdata,
	input logic [conv_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb,
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic s_axil_bvalid,
	output conv_pkg::axil_resp_t s_axil_bresp,
	input logic s_axil_bready,
	input logic [conv_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output logic [conv_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
	output conv_pkg::axil_resp_t s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	input logic pxl_valid,
	input conv_pkg::pixel_t pxl_data,
	output logic pxl_ready,
	output logic out_valid,
	output conv_pkg::result_t out_data,
	input logic out_ready
);
	import conv_pkg::*;

	lane_weights_t [N_LANES-1:0] weights;
	logic win_valid;
	window_t win_data;
	logic [N_LANES-1:0] lane_valid;
	logic [N_LANES-1:0] lane_last;
	acc_t [N_LANES-1:0] lane_sums;
	logic advance;

	assign pxl_ready = advance;

	conv_weight_regs #(
		.N_LANES(N_LANES)
	) u_weight_regs (
		.clk           (clk),
		.reset         (reset),
		.s_axil_awaddr (s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata  (s_axil_wdata),
		.s_axil_wstrb  (s_axil_wstrb),
		.s_axil_wvalid (s_axil_wvalid),
		.s_axil_wready (s_axil_wready),
		.s_axil_bvalid (s_axil_bvalid),
		.s_axil_bresp  (s_axil_bresp),
		.s_axil_bready (s_axil_bready),
		.s_axil_araddr (s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata  (s_axil_rdata),
		.s_axil_rresp  (s_axil_rresp),
		.s_axil_rvalid (s_axil_rvalid),
		.s_axil_rready (s_axil_rready),
		.weights       (weights)
	);

	conv_window_gen #(
		.IMAGE_WIDTH (IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT)
	) u_window_gen (
		.clk      (clk),
		.reset    (reset),
		.advance  (advance),
		.pxl_valid(pxl_valid),
		.pxl_data (pxl_data),
		.win_valid(win_valid),
		.win_data (win_data)
	);

	// one lane per output channel
	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		conv_mac_lane u_lane (
			.clk       (clk),
			.reset     (reset),
			.advance   (advance),
			.win_valid (win_valid),
			.win_data  (win_data),
			.weights   (weights[i]),
			.lane_valid(lane_valid[i]),
			.lane_sum  (lane_sums[i]),
			.lane_last (lane_last[i])
		);
	end

	// lanes run in lockstep, lane 0 carries the flags
	conv_result_serializer #(
		.N_LANES(N_LANES)
	) u_serializer (
		.clk       (clk),
		.reset     (reset),
		.out_ready (out_ready),
		.lane_valid(lane_valid[0]),
		.lane_last (lane_last[0]),
		.lane_sums (lane_sums),
		.advance   (advance),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// File: conv_result_serializer.sv
module conv_result_serializer #(
	parameter int N_LANES = 4
) (
	input logic clk,
	input logic reset,
	input logic out_ready,
	input logic lane_valid,
	input logic lane_last,
	input conv_pkg::acc_t [N_LANES-1:0] lane_sums,
	output logic advance,
	output logic out_valid,
	output conv_pkg::result_t out_data
);
	import conv_pkg::*;

	localparam int IDX_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

	acc_t [N_LANES-1:0] bank;
	logic [IDX_W-1:0] idx;
	logic busy;
	logic win_last;
	logic final_beat;
	logic load;

	assign final_beat = (idx == IDX_W'(N_LANES - 1));

	// pipeline moves when the bank is empty or about to be
	assign advance = !busy || (final_beat && out_ready);
	assign load = advance && lane_valid;

	////////////////////
	// beat control

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			idx <= '0;
			win_last <= 1'b0;
		end else if (load) begin
			busy <= 1'b1;
			idx <= '0;
			win_last <= lane_last;
		end else if (busy && out_ready) begin
			if (final_beat) begin
				busy <= 1'b0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			bank <= lane_sums;
		end
	end

	assign out_valid = busy;
	assign out_data = '{sum: bank[idx], chan: 8'(idx), last: win_last && final_beat};

	// stalled beat must hold
	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: conv_mac_lane.sv
module conv_mac_lane (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic win_valid,
	input conv_pkg::window_t win_data,
	input conv_pkg::lane_weights_t weights,
	output logic lane_valid,
	output conv_pkg::acc_t lane_sum,
	output logic lane_last
);
	import conv_pkg::*;

	// 9-bit signed pixel times 8-bit weight
	typedef logic signed [16:0] prod_t;

	prod_t prod [9];
	logic s1_valid;
	logic s1_last;
	acc_t sum;

	////////////////////
	// stage one products

	always_ff @(posedge clk) begin
		if (advance) begin
			for (int i = 0; i < 9; i++) begin
				prod[i] <= $signed({1'b0, win_data.tap[i]}) * weights.w[i];
			end
		end
	end

	// stage two sum
	always_comb begin
		sum = '0;
		for (int i = 0; i < 9; i++) begin
			sum = sum + prod[i];
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			lane_sum <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			lane_valid <= 1'b0;
			lane_last <= 1'b0;
		end else if (advance) begin
			s1_valid <= win_valid;
			s1_last <= win_data.last;
			lane_valid <= s1_valid;
			lane_last <= s1_last;
		end
	end

endmodule

// File: conv_window_gen.sv
module conv_window_gen #(
	parameter int IMAGE_WIDTH = 8,
	parameter int IMAGE_HEIGHT = 8
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic pxl_valid,
	input conv_pkg::pixel_t pxl_data,
	output logic win_valid,
	output conv_pkg::window_t win_data
);
	import conv_pkg::*;

	localparam int COL_W = $clog2(IMAGE_WIDTH);
	localparam int ROW_W = $clog2(IMAGE_HEIGHT);

	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	// lb0 holds the row above, lb1 the row above that
	pixel_t lb0 [IMAGE_WIDTH];
	pixel_t lb1 [IMAGE_WIDTH];
	pixel_t [8:0] taps;
	pixel_t [2:0] new_col;
	logic win_last;
	logic accept;
	logic col_last;
	logic row_last;
	logic interior;

	assign accept = advance && pxl_valid;
	assign col_last = (col == COL_W'(IMAGE_WIDTH - 1));
	assign row_last = (row == ROW_W'(IMAGE_HEIGHT - 1));
	assign interior = (col >= COL_W'(2)) && (row >= ROW_W'(2));

	// incoming column, top to bottom
	assign new_col[0] = lb1[col];
	assign new_col[1] = lb0[col];
	assign new_col[2] = pxl_data;

	////////////////////
	// position counters

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (col_last) begin
				col <= '0;
				row <= row_last ? '0 : row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			lb1[col] <= lb0[col];
			lb0[col] <= pxl_data;
		end
	end

	// shift window left by one column
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int r = 0; r < 3; r++) begin
				taps[r*3] <= taps[r*3+1];
				taps[r*3+1] <= taps[r*3+2];
				taps[r*3+2] <= new_col[r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end else if (advance) begin
			win_valid <= accept && interior;
			win_last <= accept && col_last && row_last;
		end
	end

	assign win_data = '{tap: taps, last: win_last};

	// the window is held for the lanes during a stall
	assert property (@(posedge clk) disable iff (reset)
		!advance |=> $stable(win_valid) && $stable(win_data));

endmodule

// File: conv_weight_regs.sv
module conv_weight_regs #(
	parameter int N_LANES = 4
) (
	input logic clk,
	input logic reset,
	input logic [conv_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input logic [conv_pkg::AXIL_DATA_W-1:0] s_axil_wdata,
	input logic [conv_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb,
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic s_axil_bvalid,
	output conv_pkg::axil_resp_t s_axil_bresp,
	input logic s_axil_bready,
	input logic [conv_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output logic [conv_pkg::AXIL_DATA_W-1:0] s_axil_rdata,
	output conv_pkg::axil_resp_t s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	output conv_pkg::lane_weights_t [N_LANES-1:0] weights
);
	import conv_pkg::*;

	typedef enum logic {
		W_IDLE,
		W_RESP
	} wr_state_t;

	wr_state_t state;
	logic aw_have;
	logic w_have;
	logic [AXIL_ADDR_W-1:0] aw_addr_q;
	weight_t w_data_q;
	logic w_strb_q;
	logic aw_take;
	logic w_take;
	logic ar_take;
	logic wr_fire;
	logic [AXIL_ADDR_W-1:0] wr_addr;
	weight_t wr_data;
	logic wr_strb;
	weight_t rd_w;

	// lane in bits 9:6, tap in bits 5:2
	function automatic logic addr_ok(input logic [AXIL_ADDR_W-1:0] addr);
		return (addr[5:2] <= 4'd8) && (int'(addr[9:6]) < N_LANES);
	endfunction

	////////////////////
	// write channel

	assign s_axil_awready = (state == W_IDLE) && !aw_have;
	assign s_axil_wready = (state == W_IDLE) && !w_have;
	assign s_axil_bvalid = (state == W_RESP);

	always_comb begin
		aw_take = s_axil_awvalid && s_axil_awready;
		w_take = s_axil_wvalid && s_axil_wready;
		// use the held beat, or the one arriving now
		wr_addr = aw_have ? aw_addr_q : s_axil_awaddr;
		wr_data = w_have ? w_data_q : s_axil_wdata[7:0];
		wr_strb = w_have ? w_strb_q : s_axil_wstrb[0];
		wr_fire = (state == W_IDLE) && (aw_have || aw_take) && (w_have || w_take);
	end

	always_ff @(posedge clk) begin
		if (aw_take) begin
			aw_addr_q <= s_axil_awaddr;
		end
		if (w_take) begin
			w_data_q <= s_axil_wdata[7:0];
			w_strb_q <= s_axil_wstrb[0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= W_IDLE;
			aw_have <= 1'b0;
			w_have <= 1'b0;
			s_axil_bresp <= OKAY;
		end else begin
			case (state)
				W_IDLE: begin
					if (wr_fire) begin
						state <= W_RESP;
						aw_have <= 1'b0;
						w_have <= 1'b0;
						s_axil_bresp <= addr_ok(wr_addr) ? OKAY : SLVERR;
					end else begin
						if (aw_take) begin
							aw_have <= 1'b1;
						end
						if (w_take) begin
							w_have <= 1'b1;
						end
					end
				end
				W_RESP: begin
					if (s_axil_bready) begin
						state <= W_IDLE;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// weight storage, cleared to zero
	always_ff @(posedge clk) begin
		if (reset) begin
			weights <= '0;
		end else if (wr_fire && wr_strb && addr_ok(wr_addr)) begin
			weights[wr_addr[9:6]].w[wr_addr[5:2]] <= wr_data;
		end
	end

	////////////////////
	// read channel

	assign s_axil_arready = !s_axil_rvalid;
	assign ar_take = s_axil_arvalid && s_axil_arready;
	assign rd_w = weights[s_axil_araddr[9:6]].w[s_axil_araddr[5:2]];

	always_ff @(posedge clk) begin
		if (reset) begin
			s_axil_rvalid <= 1'b0;
		end else if (ar_take) begin
			s_axil_rvalid <= 1'b1;
		end else if (s_axil_rready) begin
			s_axil_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_take) begin
			if (addr_ok(s_axil_araddr)) begin
				s_axil_rdata <= {{(AXIL_DATA_W-8){rd_w[7]}}, rd_w};
				s_axil_rresp <= OKAY;
			end else begin
				s_axil_rdata <= '0;
				s_axil_rresp <= SLVERR;
			end
		end
	end

	// a response only ever follows a completed write
	assert property (@(posedge clk) disable iff (reset)
		$rose(s_axil_bvalid) |-> $past(wr_fire));

endmodule

// File: conv_pkg.sv
package conv_pkg;

	////////////////////
	// data types

	// unsigned input pixel
	typedef logic [7:0] pixel_t;

	// signed kernel weight
	typedef logic signed [7:0] weight_t;

	// nine products of 255 * -128 fit in 20 bits
	typedef logic signed [19:0] acc_t;

	// taps are row-major, tap 0 at top left
	typedef struct packed {
		pixel_t [8:0] tap;
		logic last;
	} window_t;

	typedef struct packed {
		weight_t [8:0] w;
	} lane_weights_t;

	typedef struct packed {
		acc_t sum;
		logic [7:0] chan;
		logic last;
	} result_t;

	////////////////////
	// axi4-lite

	localparam int AXIL_ADDR_W = 10;
	localparam int AXIL_DATA_W = 32;

	typedef enum logic [1:0] {
		OKAY = 2'd0,
		SLVERR = 2'd2
	} axil_resp_t;

endpackage
